/* verilog/mipsIsaPkg.sv */
package mipsIsaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regIdxT;
    typedef logic [15:0] immT;
    typedef logic [4:0] shamtT;

    // Primary opcode in instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcodeT;

    // Function field of R-type, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } functT;

endpackage

/* verilog/mipsCtrlPkg.sv */
package mipsCtrlPkg;

    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXEC      = 3'd2,
        MEM       = 3'd3,
        WRITEBACK = 3'd4,
        HALTED    = 3'd7
    } cpuStateT;

    typedef enum logic [3:0] {
        ALU_AND  = 4'd0,
        ALU_OR   = 4'd1,
        ALU_XOR  = 4'd2,
        ALU_ADD  = 4'd3,
        ALU_SUB  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_LUI  = 4'd9
    } aluOpT;

    // Decoded controls for one instruction
    typedef struct packed {
        aluOpT aluOp;
        logic useImm;
        logic zeroExtImm;
        mipsIsaPkg::shamtT shamt;
        mipsIsaPkg::immT imm;
        mipsIsaPkg::regIdxT destReg;
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic isBranchEq;
        logic isBranchNe;
        logic isJump;
        logic isJumpReg;
        logic [25:0] jumpTarget;
    } ctrlT;

endpackage

/* verilog/mipsDecoder.sv */
`timescale 1ns/1ps

module mipsDecoder (
    input mipsIsaPkg::wordT instr,
    output mipsCtrlPkg::ctrlT ctrl
);

    mipsIsaPkg::opcodeT opcode;
    mipsIsaPkg::functT funct;
    mipsIsaPkg::regIdxT rt;
    mipsIsaPkg::regIdxT rd;

    assign opcode = mipsIsaPkg::opcodeT'(instr[31:26]);
    assign funct = mipsIsaPkg::functT'(instr[5:0]);
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    always_comb begin
        // Anything not matched below falls through as a no-op
        ctrl = '0;
        ctrl.aluOp = mipsCtrlPkg::ALU_ADD;
        ctrl.shamt = instr[10:6];
        ctrl.imm = instr[15:0];
        ctrl.jumpTarget = instr[25:0];
        ctrl.destReg = rt;

        case (opcode)
            mipsIsaPkg::OP_RTYPE: begin
                ctrl.destReg = rd;
                ctrl.regWrite = 1'b1;
                case (funct)
                    mipsIsaPkg::FN_ADDU: ctrl.aluOp = mipsCtrlPkg::ALU_ADD;
                    mipsIsaPkg::FN_SUBU: ctrl.aluOp = mipsCtrlPkg::ALU_SUB;
                    mipsIsaPkg::FN_AND:  ctrl.aluOp = mipsCtrlPkg::ALU_AND;
                    mipsIsaPkg::FN_OR:   ctrl.aluOp = mipsCtrlPkg::ALU_OR;
                    mipsIsaPkg::FN_XOR:  ctrl.aluOp = mipsCtrlPkg::ALU_XOR;
                    mipsIsaPkg::FN_SLT:  ctrl.aluOp = mipsCtrlPkg::ALU_SLT;
                    mipsIsaPkg::FN_SLTU: ctrl.aluOp = mipsCtrlPkg::ALU_SLTU;
                    mipsIsaPkg::FN_SLL:  ctrl.aluOp = mipsCtrlPkg::ALU_SLL;
                    mipsIsaPkg::FN_SRL:  ctrl.aluOp = mipsCtrlPkg::ALU_SRL;
                    mipsIsaPkg::FN_JR: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.isJumpReg = 1'b1;
                    end
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            mipsIsaPkg::OP_ADDIU: begin
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsIsaPkg::OP_SLTI: begin
                ctrl.aluOp = mipsCtrlPkg::ALU_SLT;
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsIsaPkg::OP_ANDI,
            mipsIsaPkg::OP_ORI,
            mipsIsaPkg::OP_XORI: begin
                ctrl.aluOp = (opcode == mipsIsaPkg::OP_ANDI) ? mipsCtrlPkg::ALU_AND :
                             (opcode == mipsIsaPkg::OP_ORI) ? mipsCtrlPkg::ALU_OR :
                             mipsCtrlPkg::ALU_XOR;
                // Logical immediates are zero extended
                ctrl.useImm = 1'b1;
                ctrl.zeroExtImm = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsIsaPkg::OP_LUI: begin
                ctrl.aluOp = mipsCtrlPkg::ALU_LUI;
                ctrl.useImm = 1'b1;
                ctrl.zeroExtImm = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsIsaPkg::OP_LW: begin
                ctrl.useImm = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsIsaPkg::OP_SW: begin
                ctrl.useImm = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            mipsIsaPkg::OP_BEQ: begin
                ctrl.aluOp = mipsCtrlPkg::ALU_SUB;
                ctrl.isBranchEq = 1'b1;
            end
            mipsIsaPkg::OP_BNE: begin
                ctrl.aluOp = mipsCtrlPkg::ALU_SUB;
                ctrl.isBranchNe = 1'b1;
            end
            mipsIsaPkg::OP_J: ctrl.isJump = 1'b1;
            default: ctrl.regWrite = 1'b0;
        endcase
    end

endmodule

/* verilog/mipsAlu.sv */
`timescale 1ns/1ps

module mipsAlu (
    input mipsCtrlPkg::aluOpT op,
    input mipsIsaPkg::wordT a,
    input mipsIsaPkg::wordT b,
    input mipsIsaPkg::shamtT shamt,
    output mipsIsaPkg::wordT result,
    output logic zero
);

    logic lessSigned;
    logic lessUnsigned;

    assign lessSigned = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (op)
            mipsCtrlPkg::ALU_AND:  result = a & b;
            mipsCtrlPkg::ALU_OR:   result = a | b;
            mipsCtrlPkg::ALU_XOR:  result = a ^ b;
            mipsCtrlPkg::ALU_ADD:  result = a + b;
            mipsCtrlPkg::ALU_SUB:  result = a - b;
            mipsCtrlPkg::ALU_SLT:  result = {31'b0, lessSigned};
            mipsCtrlPkg::ALU_SLTU: result = {31'b0, lessUnsigned};
            // Shifts act on rt, which arrives on b
            mipsCtrlPkg::ALU_SLL:  result = b << shamt;
            mipsCtrlPkg::ALU_SRL:  result = b >> shamt;
            mipsCtrlPkg::ALU_LUI:  result = {b[15:0], 16'h0000};
            default:               result = a + b;
        endcase
    end

    // Used by BEQ/BNE after a subtract
    assign zero = (result == '0);

endmodule

/* verilog/mipsRegisterFile.sv */
`timescale 1ns/1ps

module mipsRegisterFile (
    input logic clk,
    input logic reset,
    input mipsIsaPkg::regIdxT rdIdxA,
    input mipsIsaPkg::regIdxT rdIdxB,
    output mipsIsaPkg::wordT rdDataA,
    output mipsIsaPkg::wordT rdDataB,
    input logic wrEn,
    input mipsIsaPkg::regIdxT wrIdx,
    input mipsIsaPkg::wordT wrData,
    output mipsIsaPkg::wordT registerV0
);

    mipsIsaPkg::wordT regs [0:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrIdx != 5'd0) begin
            regs[wrIdx] <= wrData;
        end
    end

    assign rdDataA = regs[rdIdxA];
    assign rdDataB = regs[rdIdxB];

    // v0 tap for the outside world
    assign registerV0 = regs[2];

    // $zero survives any attempted write
    zeroRegHolds: assert property (
        @(posedge clk) disable iff (reset)
        wrEn && wrIdx == 5'd0 |=> regs[0] == '0
    ) else $error("register 0 changed after a write to it");

endmodule

/* verilog/mipsControl.sv */
`timescale 1ns/1ps

module mipsControl #(
    parameter mipsIsaPkg::wordT resetVector = 32'hBFC0_0000
) (
    input logic clk,
    input logic reset,
    input mipsCtrlPkg::ctrlT ctrl,
    output mipsIsaPkg::wordT instr,
    output mipsIsaPkg::regIdxT rdIdxA,
    output mipsIsaPkg::regIdxT rdIdxB,
    input mipsIsaPkg::wordT rdDataA,
    input mipsIsaPkg::wordT rdDataB,
    output logic wrEn,
    output mipsIsaPkg::regIdxT wrIdx,
    output mipsIsaPkg::wordT wrData,
    output mipsCtrlPkg::aluOpT aluOp,
    output mipsIsaPkg::wordT aluA,
    output mipsIsaPkg::wordT aluB,
    output mipsIsaPkg::shamtT aluShamt,
    input mipsIsaPkg::wordT aluResult,
    input logic aluZero,
    output logic active,
    output mipsIsaPkg::wordT address,
    output logic write,
    output logic read,
    input logic waitrequest,
    output mipsIsaPkg::wordT writedata,
    output logic [3:0] byteenable,
    input mipsIsaPkg::wordT readdata
);

    mipsCtrlPkg::cpuStateT state;
    mipsIsaPkg::wordT pc;
    mipsIsaPkg::wordT pcPlus4;
    mipsIsaPkg::wordT opA;
    mipsIsaPkg::wordT opB;
    mipsIsaPkg::wordT result;
    mipsIsaPkg::wordT immExt;
    mipsIsaPkg::wordT branchTarget;
    mipsIsaPkg::wordT jumpTarget;
    mipsIsaPkg::wordT target;
    logic booting;
    logic takeBranch;
    logic branchTaken;
    logic delaySlot;
    logic memAccess;

    assign pcPlus4 = pc + 32'd4;

    // Register read ports come straight from the latched word
    assign rdIdxA = instr[25:21];
    assign rdIdxB = instr[20:16];

    assign immExt = ctrl.zeroExtImm ? {16'h0000, ctrl.imm} : {{16{ctrl.imm[15]}}, ctrl.imm};

    assign aluOp = ctrl.aluOp;
    assign aluA = opA;
    assign aluB = ctrl.useImm ? immExt : opB;
    assign aluShamt = ctrl.shamt;

    assign branchTarget = pcPlus4 + {{14{ctrl.imm[15]}}, ctrl.imm, 2'b00};
    assign jumpTarget = {pcPlus4[31:28], ctrl.jumpTarget, 2'b00};
    assign takeBranch = (ctrl.isBranchEq && aluZero) || (ctrl.isBranchNe && !aluZero) ||
                        ctrl.isJump || ctrl.isJumpReg;

    assign wrEn = (state == mipsCtrlPkg::WRITEBACK) && ctrl.regWrite;
    assign wrIdx = ctrl.destReg;
    assign wrData = result;

    // Bus master
    assign memAccess = ctrl.memRead || ctrl.memWrite;
    assign read = (state == mipsCtrlPkg::FETCH && !booting && pc != '0) ||
                  (state == mipsCtrlPkg::MEM && ctrl.memRead);
    assign write = (state == mipsCtrlPkg::MEM) && ctrl.memWrite;
    assign address = (state == mipsCtrlPkg::FETCH) ? pc : result;
    assign writedata = opB;
    assign byteenable = (read || write) ? 4'b1111 : 4'b0000;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mipsCtrlPkg::FETCH;
            pc <= resetVector;
            booting <= 1'b1;
            active <= 1'b1;
            branchTaken <= 1'b0;
            delaySlot <= 1'b0;
        end else begin
            booting <= 1'b0;
            case (state)
                mipsCtrlPkg::FETCH: begin
                    // Bus stays idle for one cycle after reset
                    if (!booting) begin
                        if (pc == '0) begin
                            state <= mipsCtrlPkg::HALTED;
                            active <= 1'b0;
                        end else if (!waitrequest) begin
                            state <= mipsCtrlPkg::DECODE;
                        end
                    end
                end
                mipsCtrlPkg::DECODE: state <= mipsCtrlPkg::EXEC;
                mipsCtrlPkg::EXEC: begin
                    state <= mipsCtrlPkg::MEM;
                    if (takeBranch) begin
                        branchTaken <= 1'b1;
                    end
                end
                mipsCtrlPkg::MEM: begin
                    if (!memAccess || !waitrequest) begin
                        state <= mipsCtrlPkg::WRITEBACK;
                    end
                end
                mipsCtrlPkg::WRITEBACK: begin
                    state <= mipsCtrlPkg::FETCH;
                    // Delay slot runs first, the target is loaded after it
                    pc <= delaySlot ? target : pcPlus4;
                    delaySlot <= branchTaken;
                    branchTaken <= 1'b0;
                end
                default: state <= mipsCtrlPkg::HALTED;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (state == mipsCtrlPkg::FETCH && read && !waitrequest) begin
            instr <= readdata;
        end
        if (state == mipsCtrlPkg::DECODE) begin
            opA <= rdDataA;
            opB <= rdDataB;
        end
        if (state == mipsCtrlPkg::EXEC) begin
            result <= aluResult;
            if (takeBranch) begin
                target <= ctrl.isJumpReg ? opA : (ctrl.isJump ? jumpTarget : branchTarget);
            end
        end
        // Load data replaces the address once the read completes
        if (state == mipsCtrlPkg::MEM && ctrl.memRead && !waitrequest) begin
            result <= readdata;
        end
    end

    busExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(read && write)
    ) else $error("read and write asserted together");

    busAligned: assert property (
        @(posedge clk) disable iff (reset)
        (read || write) |-> address[1:0] == 2'b00
    ) else $error("unaligned bus address %h", address);

    busHeldDuringWait: assert property (
        @(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable(read) && $stable(write) && $stable(address) && $stable(byteenable) &&
            (!write || $stable(writedata))
    ) else $error("bus outputs changed while waitrequest was high");

endmodule

/* verilog/mipsCpuBus.sv */
`timescale 1ns/1ps

module mipsCpuBus #(
    parameter mipsIsaPkg::wordT resetVector = 32'hBFC0_0000
) (
    input logic clk,
    input logic reset,
    output logic active,
    output mipsIsaPkg::wordT registerV0,
    output mipsIsaPkg::wordT address,
    output logic write,
    output logic read,
    input logic waitrequest,
    output mipsIsaPkg::wordT writedata,
    output logic [3:0] byteenable,
    input mipsIsaPkg::wordT readdata
);

    mipsCtrlPkg::ctrlT ctrl;
    mipsIsaPkg::wordT instr;
    mipsIsaPkg::regIdxT rdIdxA;
    mipsIsaPkg::regIdxT rdIdxB;
    mipsIsaPkg::wordT rdDataA;
    mipsIsaPkg::wordT rdDataB;
    logic wrEn;
    mipsIsaPkg::regIdxT wrIdx;
    mipsIsaPkg::wordT wrData;
    mipsCtrlPkg::aluOpT aluOp;
    mipsIsaPkg::wordT aluA;
    mipsIsaPkg::wordT aluB;
    mipsIsaPkg::shamtT aluShamt;
    mipsIsaPkg::wordT aluResult;
    logic aluZero;

    mipsControl #(
        .resetVector(resetVector)
    ) controlInst (
        .clk(clk),
        .reset(reset),
        .ctrl(ctrl),
        .instr(instr),
        .rdIdxA(rdIdxA),
        .rdIdxB(rdIdxB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wrEn(wrEn),
        .wrIdx(wrIdx),
        .wrData(wrData),
        .aluOp(aluOp),
        .aluA(aluA),
        .aluB(aluB),
        .aluShamt(aluShamt),
        .aluResult(aluResult),
        .aluZero(aluZero),
        .active(active),
        .address(address),
        .write(write),
        .read(read),
        .waitrequest(waitrequest),
        .writedata(writedata),
        .byteenable(byteenable),
        .readdata(readdata)
    );

    mipsDecoder decoderInst (
        .instr(instr),
        .ctrl(ctrl)
    );

    mipsRegisterFile regFileInst (
        .clk(clk),
        .reset(reset),
        .rdIdxA(rdIdxA),
        .rdIdxB(rdIdxB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wrEn(wrEn),
        .wrIdx(wrIdx),
        .wrData(wrData),
        .registerV0(registerV0)
    );

    mipsAlu aluInst (
        .op(aluOp),
        .a(aluA),
        .b(aluB),
        .shamt(aluShamt),
        .result(aluResult),
        .zero(aluZero)
    );

endmodule

/* test/avalonMemoryModel.sv */
`timescale 1ns/1ps

module avalonMemoryModel #(
    parameter mipsIsaPkg::wordT bootBase = 32'hBFC0_0000,
    parameter int maxWait = 8,
    parameter logic [31:0] seed = 32'h4ddd_e0f4
) (
    input logic clk,
    input logic reset,
    input logic randomWait,
    input mipsIsaPkg::wordT address,
    input logic read,
    input logic write,
    input mipsIsaPkg::wordT writedata,
    input logic [3:0] byteenable,
    output logic waitrequest,
    output mipsIsaPkg::wordT readdata,
    output logic holdError,
    output logic addressError,
    output int writeCount
);

    // 1 KiB each, boot code at bootBase and data at address 0
    mipsIsaPkg::wordT bootMem [0:255];
    mipsIsaPkg::wordT dataMem [0:255];

    logic inBoot;
    logic inData;
    logic pending;
    logic [5:0] heldCtrl;
    mipsIsaPkg::wordT heldAddress;
    mipsIsaPkg::wordT heldData;

    assign inBoot = address[31:10] == bootBase[31:10];
    assign inData = address[31:10] == 22'd0;
    assign readdata = inBoot ? bootMem[address[9:2]] : dataMem[address[9:2]];

    initial begin
        int waitRun;
        waitrequest = 1'b0;
        waitRun = 0;
        void'($urandom(seed));
        forever begin
            @(posedge clk);
            // Stalls are capped so every access completes
            if (!reset && randomWait && waitRun < maxWait && ($urandom % 2) == 1) begin
                waitrequest <= 1'b1;
                waitRun = waitRun + 1;
            end else begin
                waitrequest <= 1'b0;
                waitRun = 0;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            holdError <= 1'b0;
            addressError <= 1'b0;
            writeCount <= 0;
        end else begin
            // Master must hold everything while stalled
            if (pending && ({read, write, byteenable} != heldCtrl || address != heldAddress ||
                    (write && writedata != heldData))) begin
                holdError <= 1'b1;
            end
            if ((read || write) && !inBoot && !inData) begin
                addressError <= 1'b1;
            end
            if (write && !waitrequest && inData) begin
                dataMem[address[9:2]] = writedata;
                writeCount <= writeCount + 1;
            end
            pending <= (read || write) && waitrequest;
            heldCtrl <= {read, write, byteenable};
            heldAddress <= address;
            heldData <= writedata;
        end
    end

endmodule

/* test/mipsCpuBusTb.sv */
`timescale 1ns/1ps

module mipsCpuBusTb;

    localparam mipsIsaPkg::wordT bootAddress = 32'hBFC0_0000;
    localparam int maxWait = 8;
    // Worst case per run is the longest program with two stalled accesses per instruction
    localparam int maxInstr = 60;
    localparam int cyclesPerInstr = 5 + 2 * maxWait;
    localparam int runOverhead = 100;
    localparam int runCount = 7;
    localparam int timeoutCycles = 2 * runCount * (maxInstr * cyclesPerInstr + runOverhead);

    logic clk;
    logic reset;
    logic randomWait;
    logic active;
    mipsIsaPkg::wordT registerV0;
    mipsIsaPkg::wordT address;
    logic write;
    logic read;
    logic waitrequest;
    mipsIsaPkg::wordT writedata;
    logic [3:0] byteenable;
    mipsIsaPkg::wordT readdata;
    logic holdError;
    logic addressError;
    int writeCount;

    string testName;
    int errorCount = 0;
    int cycleCount = 0;
    int progLen = 0;
    logic resetPrev = 1'b0;

    mipsCpuBus #(
        .resetVector(bootAddress)
    ) dut_i (
        .clk(clk),
        .reset(reset),
        .active(active),
        .registerV0(registerV0),
        .address(address),
        .write(write),
        .read(read),
        .waitrequest(waitrequest),
        .writedata(writedata),
        .byteenable(byteenable),
        .readdata(readdata)
    );

    avalonMemoryModel #(
        .bootBase(bootAddress),
        .maxWait(maxWait),
        .seed(32'h4ddd_e0f4)
    ) mem_i (
        .clk(clk),
        .reset(reset),
        .randomWait(randomWait),
        .address(address),
        .read(read),
        .write(write),
        .writedata(writedata),
        .byteenable(byteenable),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .holdError(holdError),
        .addressError(addressError),
        .writeCount(writeCount)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic mipsIsaPkg::wordT encodeR(mipsIsaPkg::regIdxT rs, mipsIsaPkg::regIdxT rt,
            mipsIsaPkg::regIdxT rd, mipsIsaPkg::shamtT sh, mipsIsaPkg::functT fn);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic mipsIsaPkg::wordT encodeI(mipsIsaPkg::opcodeT op, mipsIsaPkg::regIdxT rs,
            mipsIsaPkg::regIdxT rt, mipsIsaPkg::immT imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mipsIsaPkg::wordT encodeJ(mipsIsaPkg::opcodeT op,
            mipsIsaPkg::wordT byteAddr);
        return {op, byteAddr[27:2]};
    endfunction

    function automatic mipsIsaPkg::wordT signExtend(mipsIsaPkg::immT imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // Halves swapped so every address bit shows up in the word
    function automatic mipsIsaPkg::wordT fillWord(mipsIsaPkg::wordT byteAddr);
        return {byteAddr[15:0], byteAddr[31:16]} ^ 32'hA5A5_5A5A;
    endfunction

    task automatic stopOnFailure(string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        errorCount++;
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic checkWord(string what, mipsIsaPkg::wordT expected, mipsIsaPkg::wordT actual);
        assert (actual === expected) else begin
            stopOnFailure($sformatf("ERR %s %s: expected %h, actual %h", testName, what,
                expected, actual));
        end
    endtask

    task automatic clearMemory();
        for (int i = 0; i < 256; i++) begin
            mem_i.bootMem[i] = 32'h0000_0000;
            mem_i.dataMem[i] = fillWord(32'(i) << 2);
        end
        progLen = 0;
    endtask

    task automatic emit(mipsIsaPkg::wordT word);
        mem_i.bootMem[progLen] = word;
        progLen++;
    endtask

    // JR $0 with a NOP in its delay slot
    task automatic emitHalt();
        emit(encodeR(5'd0, 5'd0, 5'd0, 5'd0, mipsIsaPkg::FN_JR));
        emit(32'h0000_0000);
    endtask

    task automatic runProgram(string name);
        testName = randomWait ? {name, " with wait states"} : name;
        assert (progLen <= maxInstr) else stopOnFailure("program longer than the timeout allows");
        @(posedge clk);
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        while (!read) begin
            @(negedge clk);
        end
        checkWord("first fetch address", bootAddress, address);
        assert (active === 1'b1) else stopOnFailure("active is low after reset");
        while (active) begin
            @(negedge clk);
        end
        repeat (50) begin
            @(negedge clk);
            assert (!read && !write) else stopOnFailure("bus access after the core halted");
        end
    endtask

    task automatic arithmeticTest();
        mipsIsaPkg::wordT t0;
        mipsIsaPkg::wordT t1;
        mipsIsaPkg::wordT t2;
        mipsIsaPkg::wordT sum;
        mipsIsaPkg::wordT diff;
        mipsIsaPkg::wordT expected;
        clearMemory();
        emit(encodeI(mipsIsaPkg::OP_LUI, 5'd0, 5'd8, 16'h8000));
        emit(encodeI(mipsIsaPkg::OP_ORI, 5'd8, 5'd8, 16'h1234));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd0, 5'd9, 16'hFFFB));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd0, 5'd10, 16'h0003));
        emit(encodeR(5'd9, 5'd10, 5'd11, 5'd0, mipsIsaPkg::FN_SLT));
        emit(encodeR(5'd10, 5'd9, 5'd12, 5'd0, mipsIsaPkg::FN_SLTU));
        emit(encodeI(mipsIsaPkg::OP_SLTI, 5'd9, 5'd13, 16'hFFFC));
        emit(encodeR(5'd8, 5'd9, 5'd14, 5'd0, mipsIsaPkg::FN_ADDU));
        emit(encodeR(5'd10, 5'd8, 5'd15, 5'd0, mipsIsaPkg::FN_SUBU));
        emit(encodeR(5'd14, 5'd15, 5'd16, 5'd0, mipsIsaPkg::FN_AND));
        emit(encodeR(5'd14, 5'd15, 5'd17, 5'd0, mipsIsaPkg::FN_OR));
        emit(encodeR(5'd16, 5'd17, 5'd18, 5'd0, mipsIsaPkg::FN_SUBU));
        emit(encodeI(mipsIsaPkg::OP_ANDI, 5'd9, 5'd19, 16'hF0F0));
        emit(encodeI(mipsIsaPkg::OP_XORI, 5'd8, 5'd20, 16'hFFFF));
        emit(encodeR(5'd0, 5'd8, 5'd21, 5'd4, mipsIsaPkg::FN_SLL));
        emit(encodeR(5'd0, 5'd9, 5'd22, 5'd28, mipsIsaPkg::FN_SRL));
        emit(encodeR(5'd0, 5'd11, 5'd11, 5'd4, mipsIsaPkg::FN_SLL));
        emit(encodeR(5'd0, 5'd12, 5'd12, 5'd6, mipsIsaPkg::FN_SLL));
        emit(encodeR(5'd0, 5'd13, 5'd13, 5'd8, mipsIsaPkg::FN_SLL));
        emit(encodeR(5'd18, 5'd19, 5'd2, 5'd0, mipsIsaPkg::FN_ADDU));
        emit(encodeR(5'd2, 5'd20, 5'd2, 5'd0, mipsIsaPkg::FN_XOR));
        emit(encodeR(5'd2, 5'd21, 5'd2, 5'd0, mipsIsaPkg::FN_ADDU));
        emit(encodeR(5'd2, 5'd22, 5'd2, 5'd0, mipsIsaPkg::FN_XOR));
        emit(encodeR(5'd2, 5'd11, 5'd2, 5'd0, mipsIsaPkg::FN_ADDU));
        emit(encodeR(5'd2, 5'd12, 5'd2, 5'd0, mipsIsaPkg::FN_ADDU));
        emit(encodeR(5'd2, 5'd13, 5'd2, 5'd0, mipsIsaPkg::FN_ADDU));
        emitHalt();
        runProgram("arithmetic");
        t0 = {16'h8000, 16'h0000} | 32'h0000_1234;
        t1 = signExtend(16'hFFFB);
        t2 = 32'd3;
        sum = t0 + t1;
        diff = t2 - t0;
        expected = ((sum & diff) - (sum | diff)) + (t1 & 32'h0000_F0F0);
        expected = expected ^ (t0 ^ 32'h0000_FFFF);
        expected = expected + (t0 << 4);
        expected = expected ^ (t1 >> 28);
        // Compare flags land at bits 4, 6 and 8
        expected = expected + (($signed(t1) < $signed(t2)) ? 32'h10 : 32'h0);
        expected = expected + ((t2 < t1) ? 32'h40 : 32'h0);
        expected = expected + (($signed(t1) < $signed(signExtend(16'hFFFC))) ? 32'h100 : 32'h0);
        checkWord("v0", expected, registerV0);
    endtask

    task automatic loadStoreTest();
        mipsIsaPkg::wordT stored;
        mipsIsaPkg::wordT negated;
        clearMemory();
        emit(encodeI(mipsIsaPkg::OP_LUI, 5'd0, 5'd8, 16'h1234));
        emit(encodeI(mipsIsaPkg::OP_ORI, 5'd8, 5'd8, 16'h5678));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd0, 5'd9, 16'h0040));
        emit(encodeR(5'd0, 5'd8, 5'd10, 5'd0, mipsIsaPkg::FN_SUBU));
        emit(encodeI(mipsIsaPkg::OP_SW, 5'd9, 5'd8, 16'h0000));
        emit(encodeI(mipsIsaPkg::OP_SW, 5'd9, 5'd10, 16'h0008));
        emit(encodeI(mipsIsaPkg::OP_LW, 5'd9, 5'd11, 16'h0008));
        emit(encodeI(mipsIsaPkg::OP_LW, 5'd9, 5'd2, 16'h0000));
        // Untouched word still holds its fill value
        emit(encodeI(mipsIsaPkg::OP_LW, 5'd9, 5'd12, 16'h0010));
        emit(encodeR(5'd2, 5'd11, 5'd2, 5'd0, mipsIsaPkg::FN_SUBU));
        emit(encodeR(5'd2, 5'd12, 5'd2, 5'd0, mipsIsaPkg::FN_XOR));
        emitHalt();
        runProgram("loads and stores");
        stored = 32'h1234_5678;
        negated = 32'h0 - stored;
        checkWord("v0", (stored - negated) ^ fillWord(32'h50), registerV0);
        checkWord("word at 0x40", stored, mem_i.dataMem[16]);
        checkWord("word at 0x44", fillWord(32'h44), mem_i.dataMem[17]);
        checkWord("word at 0x48", negated, mem_i.dataMem[18]);
        checkWord("write count", 32'd2, writeCount);
    endtask

    task automatic branchDelayTest();
        int delayRuns;
        int fallThroughRuns;
        clearMemory();
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd0, 5'd8, 16'h0005));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd0, 5'd9, 16'h0005));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd0, 5'd10, 16'h0007));
        // Delay slots add 1, fall-through adds 0x10, skipped code adds 0x100
        emit(encodeI(mipsIsaPkg::OP_BEQ, 5'd8, 5'd9, 16'h0002));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd2, 5'd2, 16'h0001));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd2, 5'd2, 16'h0100));
        emit(encodeI(mipsIsaPkg::OP_BEQ, 5'd8, 5'd10, 16'h0002));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd2, 5'd2, 16'h0001));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd2, 5'd2, 16'h0010));
        emit(encodeI(mipsIsaPkg::OP_BNE, 5'd8, 5'd10, 16'h0002));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd2, 5'd2, 16'h0001));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd2, 5'd2, 16'h0100));
        emit(encodeI(mipsIsaPkg::OP_BNE, 5'd8, 5'd9, 16'h0002));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd2, 5'd2, 16'h0001));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd2, 5'd2, 16'h0010));
        emit(encodeJ(mipsIsaPkg::OP_J, bootAddress + 32'd72));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd2, 5'd2, 16'h0001));
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd2, 5'd2, 16'h0100));
        emitHalt();
        runProgram("branch delay slots");
        delayRuns = 5;
        fallThroughRuns = 2;
        checkWord("v0", 32'(delayRuns + 16 * fallThroughRuns), registerV0);
    endtask

    // v0 must start from zero after reset whatever the last run left
    task automatic resetHaltTest();
        clearMemory();
        emit(encodeI(mipsIsaPkg::OP_ADDIU, 5'd2, 5'd2, 16'h8001));
        emitHalt();
        runProgram("reset and halt");
        checkWord("v0", signExtend(16'h8001), registerV0);
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            stopOnFailure($sformatf("timeout after %0d cycles, the core never halted",
                cycleCount));
        end
    end

    always @(negedge clk) begin
        if (resetPrev) begin
            assert (!read && !write) else stopOnFailure("bus access while reset was applied");
        end
        if (read || write) begin
            checkWord("byteenable", 32'h0000_000F, {28'h0, byteenable});
        end
        assert (!holdError) else begin
            stopOnFailure("bus outputs changed while waitrequest was high");
        end
        assert (!addressError) else stopOnFailure("bus access outside the mapped memory");
        resetPrev = reset;
    end

    initial begin
        reset = 1'b1;
        randomWait = 1'b0;
        testName = "startup";
        arithmeticTest();
        loadStoreTest();
        branchDelayTest();
        resetHaltTest();
        randomWait = 1'b1;
        arithmeticTest();
        loadStoreTest();
        branchDelayTest();
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
verilog/mipsIsaPkg.sv
verilog/mipsCtrlPkg.sv
verilog/mipsDecoder.sv
verilog/mipsAlu.sv
verilog/mipsRegisterFile.sv
verilog/mipsControl.sv
verilog/mipsCpuBus.sv
test/avalonMemoryModel.sv
test/mipsCpuBusTb.sv
